//--- design/data_mem.sv
`include "lsu_defines.svh"

module data_mem (
    input  logic              clk_i,
    input  logic              we_i,
    input  logic              re_i,
    input  lsu_pkg::mem_idx_t idx_i,
    input  lsu_pkg::mask_t    wmask_i,
    input  lsu_pkg::data_t    wdata_i,
    output lsu_pkg::data_t    rdata_o
);
    import lsu_pkg::*;

    data_t mem [`LSU_MEM_WORDS];

    // Bit-masked write, untouched bits keep their old value
    always_ff @(posedge clk_i) begin
        if (we_i) begin
            mem[idx_i] <= (mem[idx_i] & ~wmask_i) | (wdata_i & wmask_i);
        end
    end

    // Whole word is read, the result stage picks the bytes
    always_ff @(posedge clk_i) begin
        if (re_i) begin
            rdata_o <= mem[idx_i];
        end
    end

endmodule

//--- design/load_result_align.sv
module load_result_align (
    input  logic              clk_i,
    input  logic              rst_n_i,
    load_meta_if.dst          meta_i,
    input  lsu_pkg::data_t    rdata_i,
    output logic              load_valid_o,
    output lsu_pkg::reg_idx_t load_rd_o,
    output lsu_pkg::data_t    load_data_o
);
    import lsu_pkg::*;

    data_t result;
    logic  fill;

    // Extension bit taken from the top of the word
    assign fill = meta_i.sign_ext & rdata_i[31];

    always_comb begin
        case (meta_i.size)
            ACC_HALF: result = {{16{fill}}, rdata_i[31:16]};
            ACC_BYTE: result = {{24{fill}}, rdata_i[31:24]};
            default:  result = rdata_i;  // Word passes through
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            load_valid_o <= 1'b0;
            load_rd_o    <= '0;
            load_data_o  <= '0;
        end else begin
            load_valid_o <= meta_i.valid;
            if (meta_i.valid) begin
                load_rd_o   <= meta_i.rd;
                load_data_o <= result;
            end
        end
    end

endmodule

//--- design/lsu_ifs.sv
// Decoded memory micro-op, decode stage to execute stage
interface decoded_uop_if;
    import lsu_pkg::*;

    logic      valid;
    logic      is_load;
    logic      is_store;
    acc_size_t size;
    logic      sign_ext;   // Only meaningful for half and byte loads
    data_t     rs1;
    data_t     rs2;
    imm_t      imm;
    reg_idx_t  rd;

    modport src (
        output valid, is_load, is_store, size, sign_ext, rs1, rs2, imm, rd
    );

    modport dst (
        input valid, is_load, is_store, size, sign_ext, rs1, rs2, imm, rd
    );

endinterface

// Load bookkeeping that travels beside the memory read
interface load_meta_if;
    import lsu_pkg::*;

    logic      valid;
    acc_size_t size;
    logic      sign_ext;
    reg_idx_t  rd;

    modport src (
        output valid, size, sign_ext, rd
    );

    modport dst (
        input valid, size, sign_ext, rd
    );

endinterface

//--- design/lsu_pkg.sv
`include "lsu_defines.svh"

package lsu_pkg;

    typedef logic [`LSU_DATA_W-1:0]        data_t;
    typedef logic [`LSU_ADDR_W-1:0]        addr_t;
    typedef logic signed [`LSU_IMM_W-1:0]  imm_t;
    typedef logic [`LSU_DATA_W-1:0]        mask_t;
    typedef logic [4:0]                    reg_idx_t;
    typedef logic [`LSU_MEM_IDX_W-1:0]     mem_idx_t;
    typedef logic [3:0]                    mem_op_t;
    typedef logic [1:0]                    acc_size_t;

    // Memory micro-op codes, anything else behaves as NOP
    localparam mem_op_t MEM_OP_NOP = 4'd0;
    localparam mem_op_t MEM_OP_LW  = 4'd1;
    localparam mem_op_t MEM_OP_LH  = 4'd2;
    localparam mem_op_t MEM_OP_LHU = 4'd3;
    localparam mem_op_t MEM_OP_LB  = 4'd4;
    localparam mem_op_t MEM_OP_LBU = 4'd5;
    localparam mem_op_t MEM_OP_SW  = 4'd6;
    localparam mem_op_t MEM_OP_SH  = 4'd7;
    localparam mem_op_t MEM_OP_SB  = 4'd8;

    // Access sizes
    localparam acc_size_t ACC_WORD = 2'd0;
    localparam acc_size_t ACC_HALF = 2'd1;
    localparam acc_size_t ACC_BYTE = 2'd2;

endpackage

//--- design/lsu_top.sv
module lsu_top (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              uop_valid_i,
    input  lsu_pkg::mem_op_t  uop_op_i,
    input  lsu_pkg::data_t    uop_rs1_i,
    input  lsu_pkg::data_t    uop_rs2_i,
    input  lsu_pkg::imm_t     uop_imm_i,
    input  lsu_pkg::reg_idx_t uop_rd_i,
    output logic              load_valid_o,
    output lsu_pkg::reg_idx_t load_rd_o,
    output lsu_pkg::data_t    load_data_o
);
    import lsu_pkg::*;

    decoded_uop_if dec_if ();
    load_meta_if   meta_if ();

    data_t rdata;  // Memory read word beside the load metadata

    mem_uop_decode i_decode (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .uop_valid_i (uop_valid_i),
        .uop_op_i    (uop_op_i),
        .uop_rs1_i   (uop_rs1_i),
        .uop_rs2_i   (uop_rs2_i),
        .uop_imm_i   (uop_imm_i),
        .uop_rd_i    (uop_rd_i),
        .dec_o       (dec_if)
    );

    mem_access_unit i_access (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .dec_i   (dec_if),
        .meta_o  (meta_if),
        .rdata_o (rdata)
    );

    load_result_align i_align (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .meta_i       (meta_if),
        .rdata_i      (rdata),
        .load_valid_o (load_valid_o),
        .load_rd_o    (load_rd_o),
        .load_data_o  (load_data_o)
    );

endmodule

//--- design/mem_access_unit.sv
`include "lsu_defines.svh"

module mem_access_unit (
    input  logic           clk_i,
    input  logic           rst_n_i,
    decoded_uop_if.dst     dec_i,
    load_meta_if.src       meta_o,
    output lsu_pkg::data_t rdata_o
);
    import lsu_pkg::*;

    addr_t    addr;
    mask_t    mask;
    mem_idx_t idx;
    data_t    wdata;
    logic     we;
    logic     re;

    mem_addr_mask_unit i_addr_mask (
        .rs1_i  (dec_i.rs1),
        .imm_i  (dec_i.imm),
        .size_i (dec_i.size),
        .addr_o (addr),
        .mask_o (mask)
    );

    // Word addressed, so the index wraps every 1 KiB
    assign idx = addr[`LSU_MEM_IDX_W+1:2];
    assign we  = dec_i.valid & dec_i.is_store;
    assign re  = dec_i.valid & dec_i.is_load;

    // Low bytes of rs2 move up into the masked upper bytes
    always_comb begin
        case (dec_i.size)
            ACC_HALF: wdata = {dec_i.rs2[15:0], 16'h0000};
            ACC_BYTE: wdata = {dec_i.rs2[7:0], 24'h00_0000};
            default:  wdata = dec_i.rs2;
        endcase
    end

    data_mem i_data_mem (
        .clk_i   (clk_i),
        .we_i    (we),
        .re_i    (re),
        .idx_i   (idx),
        .wmask_i (mask),
        .wdata_i (wdata),
        .rdata_o (rdata_o)
    );

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            meta_o.valid <= 1'b0;
        end else begin
            meta_o.valid <= re;  // Lines up with the registered read
        end
    end

    always_ff @(posedge clk_i) begin
        if (re) begin
            meta_o.size     <= dec_i.size;
            meta_o.sign_ext <= dec_i.sign_ext;
            meta_o.rd       <= dec_i.rd;
        end
    end

endmodule

//--- design/mem_addr_mask_unit.sv
`include "lsu_defines.svh"

module mem_addr_mask_unit (
    input  lsu_pkg::data_t     rs1_i,
    input  lsu_pkg::imm_t      imm_i,
    input  lsu_pkg::acc_size_t size_i,
    output lsu_pkg::addr_t     addr_o,
    output lsu_pkg::mask_t     mask_o
);
    import lsu_pkg::*;

    localparam int SEXT_W = `LSU_ADDR_W - `LSU_IMM_W;

    addr_t imm_sext;
    mask_t mask_cmb;

    // Immediate is sign-extended before the add, result wraps at 2^32
    assign imm_sext = {{SEXT_W{imm_i[`LSU_IMM_W-1]}}, imm_i};
    assign addr_o   = rs1_i + imm_sext;

    // Sub-word accesses live in the most significant bytes of the word
    always_comb begin
        case (size_i)
            ACC_WORD: mask_cmb = 32'hFFFF_FFFF;
            ACC_HALF: mask_cmb = 32'hFFFF_0000;  // Upper half word
            ACC_BYTE: mask_cmb = 32'hFF00_0000;  // Upper byte
            default:  mask_cmb = 32'h0000_0000;
        endcase
    end

    assign mask_o = mask_cmb;

endmodule

//--- design/mem_uop_decode.sv
module mem_uop_decode (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              uop_valid_i,
    input  lsu_pkg::mem_op_t  uop_op_i,
    input  lsu_pkg::data_t    uop_rs1_i,
    input  lsu_pkg::data_t    uop_rs2_i,
    input  lsu_pkg::imm_t     uop_imm_i,
    input  lsu_pkg::reg_idx_t uop_rd_i,
    decoded_uop_if.src        dec_o
);
    import lsu_pkg::*;

    logic      is_load_d;
    logic      is_store_d;
    acc_size_t size_d;
    logic      sign_ext_d;

    always_comb begin
        is_load_d  = 1'b0;
        is_store_d = 1'b0;
        size_d     = ACC_WORD;
        sign_ext_d = 1'b0;
        case (uop_op_i)
            MEM_OP_LW:  is_load_d = 1'b1;
            MEM_OP_LH:  begin is_load_d = 1'b1; size_d = ACC_HALF; sign_ext_d = 1'b1; end
            MEM_OP_LHU: begin is_load_d = 1'b1; size_d = ACC_HALF; end
            MEM_OP_LB:  begin is_load_d = 1'b1; size_d = ACC_BYTE; sign_ext_d = 1'b1; end
            MEM_OP_LBU: begin is_load_d = 1'b1; size_d = ACC_BYTE; end
            MEM_OP_SW:  is_store_d = 1'b1;
            MEM_OP_SH:  begin is_store_d = 1'b1; size_d = ACC_HALF; end
            MEM_OP_SB:  begin is_store_d = 1'b1; size_d = ACC_BYTE; end
            default:    is_load_d = 1'b0;  // NOP and unknown codes stop here
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            dec_o.valid    <= 1'b0;
            dec_o.is_load  <= 1'b0;
            dec_o.is_store <= 1'b0;
        end else begin
            dec_o.valid    <= uop_valid_i & (is_load_d | is_store_d);
            dec_o.is_load  <= is_load_d;
            dec_o.is_store <= is_store_d;
        end
    end

    // Operands only matter when valid is set
    always_ff @(posedge clk_i) begin
        if (uop_valid_i) begin
            dec_o.size     <= size_d;
            dec_o.sign_ext <= sign_ext_d;
            dec_o.rs1      <= uop_rs1_i;
            dec_o.rs2      <= uop_rs2_i;
            dec_o.imm      <= uop_imm_i;
            dec_o.rd       <= uop_rd_i;
        end
    end

endmodule

//--- include/lsu_defines.svh
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// Datapath widths
`define LSU_DATA_W 32
`define LSU_ADDR_W 32
`define LSU_IMM_W 12

// Local data memory geometry
`define LSU_MEM_WORDS 256
`define LSU_MEM_IDX_W 8    // Selects address bits 9:2

`endif

//--- lsu_top.f
+incdir+include
design/lsu_pkg.sv
design/lsu_ifs.sv
design/mem_uop_decode.sv
design/mem_addr_mask_unit.sv
design/data_mem.sv
design/mem_access_unit.sv
design/load_result_align.sv
design/lsu_top.sv
verification/tb_clk_gen.sv
verification/lsu_top_sva.sv
verification/tb_lsu_top.sv

//--- verification/lsu_top_sva.sv
module lsu_top_sva (
    input logic             clk_i,
    input logic             rst_n_i,
    input logic             uop_valid_i,
    input lsu_pkg::mem_op_t uop_op_i,
    input logic             load_valid_o
);
    timeunit 1ns;
    timeprecision 1ps;
    import lsu_pkg::*;

    logic load_in;

    assign load_in = uop_valid_i &&
        (uop_op_i inside {MEM_OP_LW, MEM_OP_LH, MEM_OP_LHU, MEM_OP_LB, MEM_OP_LBU});

    no_valid_in_reset: assert property (@(posedge clk_i) !rst_n_i |-> !load_valid_o)
        else $error("load_valid_o high while reset is held");

    // Three edges from input sample to visible result
    load_gives_result: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        load_in |-> ##3 load_valid_o)
        else $error("load accepted but no load_valid_o three cycles later");

    other_gives_none: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !load_in |-> ##3 !load_valid_o)
        else $error("load_valid_o raised for a store, NOP or idle cycle");

endmodule

//--- verification/tb_clk_gen.sv
module tb_clk_gen (
    output logic clk_o
);
    timeunit 1ns;
    timeprecision 1ps;

    // 10 ns period
    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;
    end

endmodule

//--- verification/tb_lsu_top.sv
module tb_lsu_top;
    timeunit 1ns;
    timeprecision 1ps;
    import lsu_pkg::*;

    localparam int FILL_OPS       = 256;
    localparam int READ_OPS       = 256;
    localparam int SUBWORD_OPS    = 56;   // 8 rounds of 7 ops
    localparam int NOP_OPS        = 40;
    localparam int RANDOM_OPS     = 200;
    localparam int TOTAL_OPS      = FILL_OPS + READ_OPS + SUBWORD_OPS + NOP_OPS + RANDOM_OPS;
    localparam int TIMEOUT_CYCLES = 2 * TOTAL_OPS + 50;

    logic     clk;
    logic     rst_n;
    logic     uop_valid;
    mem_op_t  uop_op;
    data_t    uop_rs1;
    data_t    uop_rs2;
    imm_t     uop_imm;
    reg_idx_t uop_rd;
    logic     load_valid;
    reg_idx_t load_rd;
    data_t    load_data;

    data_t    model [256];     // Word image of the data memory
    reg_idx_t exp_rd[$];
    data_t    exp_data[$];
    logic [31:0] rng_state = 32'h4db1_3bef;
    int       cycles = 0;
    int       loads_seen = 0;

    tb_clk_gen i_clk_gen (.clk_o(clk));

    lsu_top i_dut (
        .clk_i        (clk),
        .rst_n_i      (rst_n),
        .uop_valid_i  (uop_valid),
        .uop_op_i     (uop_op),
        .uop_rs1_i    (uop_rs1),
        .uop_rs2_i    (uop_rs2),
        .uop_imm_i    (uop_imm),
        .uop_rd_i     (uop_rd),
        .load_valid_o (load_valid),
        .load_rd_o    (load_rd),
        .load_data_o  (load_data)
    );

    bind lsu_top lsu_top_sva i_sva (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .uop_valid_i  (uop_valid_i),
        .uop_op_i     (uop_op_i),
        .load_valid_o (load_valid_o)
    );

    function automatic data_t xorshift32();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // Sub-word data sits in the top bytes of the word
    function automatic data_t expected_load(data_t word, mem_op_t op);
        case (op)
            MEM_OP_LH:  return {{16{word[31]}}, word[31:16]};
            MEM_OP_LHU: return {16'h0000, word[31:16]};
            MEM_OP_LB:  return {{24{word[31]}}, word[31:24]};
            MEM_OP_LBU: return {24'h00_0000, word[31:24]};
            default:    return word;
        endcase
    endfunction

    function automatic data_t stored_word(data_t old, data_t val, mem_op_t op);
        case (op)
            MEM_OP_SH: return {val[15:0], old[15:0]};
            MEM_OP_SB: return {val[7:0], old[23:0]};
            default:   return val;
        endcase
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1, "run stopped at %0t", $time);
    endtask

    task automatic check_value(input string name, input data_t got, input data_t exp);
        if (got !== exp)
            fail_run($sformatf("mismatch at %0t: %s got 0x%08h, expected 0x%08h",
                               $time, name, got, exp));
    endtask

    // Drives one op and updates the model in issue order
    task automatic issue(input logic valid, input mem_op_t op, input data_t rs1,
                         input imm_t imm, input data_t rs2, input reg_idx_t rd);
        data_t    addr;
        mem_idx_t idx;
        @(posedge clk);
        uop_valid <= valid;
        uop_op    <= op;
        uop_rs1   <= rs1;
        uop_imm   <= imm;
        uop_rs2   <= rs2;
        uop_rd    <= rd;
        addr = rs1 + {{20{imm[11]}}, imm};
        idx  = addr[9:2];
        if (valid && (op inside {MEM_OP_SW, MEM_OP_SH, MEM_OP_SB})) begin
            model[idx] = stored_word(model[idx], rs2, op);
        end else if (valid && (op inside {MEM_OP_LW, MEM_OP_LH, MEM_OP_LHU,
                                          MEM_OP_LB, MEM_OP_LBU})) begin
            exp_rd.push_back(rd);
            exp_data.push_back(expected_load(model[idx], op));
        end
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES)
            fail_run($sformatf("timeout after %0d cycles, stimulus did not finish", cycles));
    end

    // Outputs are compared half a cycle after they change
    always @(negedge clk) begin
        if (cycles > 0) begin  // Clock is running and reset has been applied
            if (!rst_n) begin
                check_value("load_valid_o", load_valid, '0);
                check_value("load_data_o", load_data, '0);
            end else if (load_valid) begin
                if (exp_data.size() == 0) begin
                    fail_run("load result came out with no load outstanding");
                end else begin
                    check_value("load_rd_o", load_rd, exp_rd.pop_front());
                    check_value("load_data_o", load_data, exp_data.pop_front());
                    loads_seen++;
                end
            end else if (loads_seen == 0) begin
                check_value("load_data_o", load_data, '0);  // Still the reset value
            end
        end
    end

    initial begin
        data_t   w;
        data_t   r;
        data_t   rs1;
        imm_t    imm;
        mem_op_t op;
        logic    prev_store;
        rst_n     <= 1'b0;
        uop_valid <= 1'b0;
        uop_op    <= MEM_OP_NOP;
        uop_rs1   <= '0;
        uop_rs2   <= '0;
        uop_imm   <= '0;
        uop_rd    <= '0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        for (int k = 0; k < FILL_OPS; k++)
            issue(1'b1, MEM_OP_SW, k * 4, '0, xorshift32(), reg_idx_t'(k));
        // Negative immediate, sum lands past 1 KiB and wraps to word k
        for (int k = 0; k < READ_OPS; k++)
            issue(1'b1, MEM_OP_LW, k * 4 + 1032, imm_t'(-8), xorshift32(), reg_idx_t'(k));

        for (int k = 0; k < 8; k++) begin
            w = xorshift32();
            w[15] = k[0];   // Alternates the sign of the stored half
            w[7]  = k[1];
            rs1 = (k + 32) * 4;
            issue(1'b1, MEM_OP_SH, rs1, '0, w, '0);
            issue(1'b1, MEM_OP_LH, rs1, '0, '0, reg_idx_t'(k));
            issue(1'b1, MEM_OP_LHU, rs1, '0, '0, reg_idx_t'(k + 8));
            issue(1'b1, MEM_OP_SB, rs1, '0, w, '0);
            issue(1'b1, MEM_OP_LB, rs1, '0, '0, reg_idx_t'(k + 16));
            issue(1'b1, MEM_OP_LBU, rs1, '0, '0, reg_idx_t'(k + 24));
            issue(1'b1, MEM_OP_LW, rs1, '0, '0, reg_idx_t'(k));
        end

        for (int k = 0; k < 16; k++)
            issue(1'b0, mem_op_t'(k), k * 4, '0, xorshift32(), reg_idx_t'(k));
        for (int k = 0; k < 8; k++) begin
            op = (k == 0) ? MEM_OP_NOP : mem_op_t'(k + 8);
            issue(1'b1, op, k * 4, '0, xorshift32(), '0);
        end
        for (int k = 0; k < 16; k++)
            issue(1'b1, MEM_OP_LW, k * 4, '0, '0, reg_idx_t'(k));

        prev_store = 1'b0;
        for (int k = 0; k < RANDOM_OPS; k++) begin
            r = xorshift32();
            if (prev_store && r[0]) begin
                op = mem_op_t'(1 + (r[3:1] % 5));  // Load right behind the store
            end else begin
                op  = mem_op_t'(r[7:4] % 10);
                rs1 = xorshift32();
                imm = imm_t'(xorshift32());
            end
            issue(1'b1, op, rs1, imm, xorshift32(), reg_idx_t'(k));
            prev_store = op inside {MEM_OP_SW, MEM_OP_SH, MEM_OP_SB};
        end

        @(posedge clk);
        uop_valid <= 1'b0;
        repeat (5) @(posedge clk);
        if (exp_data.size() != 0) begin
            fail_run($sformatf("%0d expected load results never came out", exp_data.size()));
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule
